/* hw/lsu_settings.svh */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data and address width
`define LSU_XLEN 32

// one enable bit per byte
`define LSU_MASK_W (`LSU_XLEN / 8)

// store buffer entries, power of two
`define LSU_SB_DEPTH 4
`define LSU_SRAM_WORDS 256

`endif

/* hw/lsu_pkg.sv */
`default_nettype none

`include "lsu_settings.svh"

package lsu_pkg;

    // one buffered store
    // a zero mask marks the slot as free
    typedef struct packed {
        logic [`LSU_XLEN-1:0]   addr;
        logic [`LSU_XLEN-1:0]   data;
        logic [`LSU_MASK_W-1:0] mask;
        // already issued to the sram
        logic                   sent;
    } sb_entry_t;

endpackage : lsu_pkg

`default_nettype wire

/* hw/dcache_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

interface dcache_if;

    // request, one-cycle strobe on a nonzero mask
    logic [`LSU_XLEN-1:0]   addr;
    logic [`LSU_MASK_W-1:0] rmask;
    logic [`LSU_MASK_W-1:0] wmask;
    logic [`LSU_XLEN-1:0]   wdata;

    // response, one cycle after the request
    logic [`LSU_XLEN-1:0]   rdata;
    logic                   resp;

    modport sb (output addr, rmask, wmask, wdata, input rdata, resp);
    modport mem (input addr, rmask, wmask, wdata, output rdata, resp);

endinterface : dcache_if

`default_nettype wire

/* hw/store_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module store_buffer (
    input  logic                   clk,
    input  logic                   rst,

    // from the memory stage
    input  logic [`LSU_XLEN-1:0]   store_addr,
    input  logic [`LSU_XLEN-1:0]   store_data,
    input  logic [`LSU_MASK_W-1:0] store_mask,
    input  logic [`LSU_XLEN-1:0]   load_addr,
    input  logic [`LSU_MASK_W-1:0] load_mask,

    // to the memory stage
    output logic                   full,
    output logic                   store_resp,
    output logic                   load_resp,
    output logic [`LSU_XLEN-1:0]   load_data,

    dcache_if.sb                   mem
);

    localparam int DEPTH = `LSU_SB_DEPTH;
    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = IDX_W + 1;

    // slot 0 is the oldest store
    lsu_pkg::sb_entry_t     ent_q [DEPTH];
    lsu_pkg::sb_entry_t     ent_d [DEPTH];

    // pending load
    logic [`LSU_XLEN-1:0]   ld_addr_q;
    logic [`LSU_MASK_W-1:0] ld_mask_q;
    logic                   rd_out_q;
    logic                   rd_out_d;
    // stores that were already buffered when the load came in
    logic [CNT_W-1:0]       ld_older_q;
    logic [CNT_W-1:0]       ld_older_d;
    logic [CNT_W-1:0]       occ_d;

    logic                   ld_pend;
    logic                   head_valid;
    logic                   issue_wr;
    logic                   issue_rd;
    logic                   pop;
    logic                   hit;
    logic [IDX_W-1:0]       fwd_idx;
    logic                   placed;

    assign ld_pend    = (ld_mask_q != '0);
    assign head_valid = (ent_q[0].mask != '0);
    assign full       = (ent_q[DEPTH-1].mask != '0);

    // head write goes out as soon as it reaches slot 0
    assign issue_wr = head_valid && !ent_q[0].sent;
    // a miss reads only from an empty buffer
    assign issue_rd = !head_valid && ld_pend && !rd_out_q;
    assign pop      = head_valid && ent_q[0].sent && mem.resp && !rd_out_q;

    // forwarding search, later slots override so the youngest match wins
    always_comb begin
        hit     = 1'b0;
        fwd_idx = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (ld_pend && (i < int'(ld_older_q)) && (ent_q[i].mask != '0) &&
                (ent_q[i].addr == ld_addr_q) && (ent_q[i].mask == ld_mask_q)) begin
                hit     = 1'b1;
                fwd_idx = IDX_W'(i);
            end
        end
    end

    assign load_resp = ld_pend && (hit || (rd_out_q && mem.resp));
    assign load_data = hit ? ent_q[fwd_idx].data : mem.rdata;

    // sram request mux
    always_comb begin
        mem.addr  = '0;
        mem.rmask = '0;
        mem.wmask = '0;
        mem.wdata = '0;
        if (issue_wr) begin
            mem.addr  = ent_q[0].addr;
            mem.wmask = ent_q[0].mask;
            mem.wdata = ent_q[0].data;
        end else if (issue_rd) begin
            mem.addr  = ld_addr_q;
            mem.rmask = ld_mask_q;
        end
    end

    // queue next state: mark, shift, then append
    always_comb begin
        placed = 1'b0;
        occ_d  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            ent_d[i] = ent_q[i];
        end

        if (issue_wr) begin
            ent_d[0].sent = 1'b1;
        end

        if (pop) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                ent_d[i] = ent_q[i+1];
            end
            ent_d[DEPTH-1] = '0;
        end

        // first free slot after the shift
        for (int i = 0; i < DEPTH; i++) begin
            if (!placed && (store_mask != '0) && (ent_d[i].mask == '0)) begin
                ent_d[i].addr = store_addr;
                ent_d[i].data = store_data;
                ent_d[i].mask = store_mask;
                ent_d[i].sent = 1'b0;
                placed        = 1'b1;
            end
        end

        for (int i = 0; i < DEPTH; i++) begin
            if (ent_d[i].mask != '0) begin
                occ_d = occ_d + 1'b1;
            end
        end
    end

    // younger stores are never visible to the pending load
    always_comb begin
        ld_older_d = ld_older_q;
        if (pop && (ld_older_q != '0)) begin
            ld_older_d = ld_older_q - 1'b1;
        end
        if (load_mask != '0) begin
            ld_older_d = occ_d;
        end
    end

    always_comb begin
        rd_out_d = rd_out_q;
        if (rd_out_q && mem.resp) begin
            rd_out_d = 1'b0;
        end
        if (issue_rd) begin
            rd_out_d = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                ent_q[i] <= '0;
            end
            store_resp <= 1'b0;
            ld_mask_q  <= '0;
            rd_out_q   <= 1'b0;
            ld_older_q <= '0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                ent_q[i] <= ent_d[i];
            end
            store_resp <= (store_mask != '0);
            rd_out_q   <= rd_out_d;
            ld_older_q <= ld_older_d;
            if (load_mask != '0) begin
                ld_mask_q <= load_mask;
            end else if (load_resp) begin
                ld_mask_q <= '0;
            end
        end
    end

    // load address only matters while the mask is set
    always_ff @(posedge clk) begin
        if (load_mask != '0) begin
            ld_addr_q <= load_addr;
        end
    end

endmodule : store_buffer

`default_nettype wire

/* hw/data_sram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module data_sram (
    input  logic clk,
    input  logic rst,
    dcache_if.mem port
);

    localparam int IDX_W = $clog2(`LSU_SRAM_WORDS);

    logic [`LSU_XLEN-1:0] mem [`LSU_SRAM_WORDS];
    logic [IDX_W-1:0]     idx;
    logic                 req;

    // word index, byte offset bits dropped
    assign idx = port.addr[IDX_W+1:2];
    assign req = (port.rmask != '0) || (port.wmask != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `LSU_SRAM_WORDS; w++) begin
                mem[w] <= '0;
            end
            port.resp <= 1'b0;
        end else begin
            port.resp <= req;
            if (port.wmask != '0) begin
                // only enabled bytes change
                for (int b = 0; b < `LSU_MASK_W; b++) begin
                    if (port.wmask[b]) begin
                        mem[idx][8*b +: 8] <= port.wdata[8*b +: 8];
                    end
                end
            end
            if (port.rmask != '0) begin
                port.rdata <= mem[idx];
            end
        end
    end

endmodule : data_sram

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_settings.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   rst,

    // store request
    input  logic [`LSU_XLEN-1:0]   store_addr,
    input  logic [`LSU_XLEN-1:0]   store_data,
    input  logic [`LSU_MASK_W-1:0] store_mask,

    // load request
    input  logic [`LSU_XLEN-1:0]   load_addr,
    input  logic [`LSU_MASK_W-1:0] load_mask,

    output logic                   full,
    output logic                   store_resp,
    output logic                   load_resp,
    output logic [`LSU_XLEN-1:0]   load_data
);

    // single port between buffer and sram
    dcache_if dc_if ();

    store_buffer sb_i (
        .clk        (clk),
        .rst        (rst),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_mask (store_mask),
        .load_addr  (load_addr),
        .load_mask  (load_mask),
        .full       (full),
        .store_resp (store_resp),
        .load_resp  (load_resp),
        .load_data  (load_data),
        .mem        (dc_if)
    );

    data_sram sram_i (
        .clk  (clk),
        .rst  (rst),
        .port (dc_if)
    );

endmodule : lsu_top

`default_nettype wire

/* tests/lsu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

    localparam int XLEN     = 32;
    localparam int MASK_W   = 4;
    localparam int DEPTH    = 4;
    localparam int WAIT_MAX = 200;
    localparam int N_RANDOM = 400;

    logic              clk;
    logic              rst;
    logic [XLEN-1:0]   store_addr;
    logic [XLEN-1:0]   store_data;
    logic [MASK_W-1:0] store_mask;
    logic [XLEN-1:0]   load_addr;
    logic [MASK_W-1:0] load_mask;
    logic              full;
    logic              store_resp;
    logic              load_resp;
    logic [XLEN-1:0]   load_data;

    // memory image after every store issued so far
    logic [7:0]        ref_bytes [1024];
    // stores still held in the buffer, oldest first
    logic [XLEN-1:0]   q_addr [$];
    logic [XLEN-1:0]   q_data [$];
    logic [MASK_W-1:0] q_mask [$];
    bit                head_sent;

    lsu_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_mask (store_mask),
        .load_addr  (load_addr),
        .load_mask  (load_mask),
        .full       (full),
        .store_resp (store_resp),
        .load_resp  (load_resp),
        .load_data  (load_data)
    );

    always #50 clk = ~clk;

    task automatic report_error(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout: waited %0d cycles for %s", WAIT_MAX, what);
        $display("Done: errors found");
        $fatal(1, "stopped on timeout");
    endtask

    // head store takes one issue cycle and one response cycle
    always @(posedge clk) begin
        if (rst) begin
            q_addr.delete();
            q_data.delete();
            q_mask.delete();
            head_sent = 1'b0;
        end else begin
            if (q_addr.size() > 0) begin
                if (head_sent) begin
                    void'(q_addr.pop_front());
                    void'(q_data.pop_front());
                    void'(q_mask.pop_front());
                    head_sent = 1'b0;
                end else begin
                    head_sent = 1'b1;
                end
            end
            if (store_mask != '0) begin
                q_addr.push_back(store_addr);
                q_data.push_back(store_data);
                q_mask.push_back(store_mask);
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            assert (full == (q_addr.size() == DEPTH))
            else report_error($sformatf("full is %b with %0d stores buffered",
                                        full, q_addr.size()));
        end
    end

    store_ack_follows: assert property (@(posedge clk) disable iff (rst)
        (store_mask != '0) |=> store_resp)
        else report_error("store_resp missing one cycle after a store strobe");

    store_ack_only_after_strobe: assert property (@(posedge clk) disable iff (rst)
        store_resp |-> $past(store_mask != '0))
        else report_error("store_resp high without a store strobe before it");

    no_store_while_full: assert property (@(posedge clk) disable iff (rst)
        (store_mask != '0) |-> !full)
        else report_error("store strobed while full was high");

    // buffer size after the next edge
    function automatic int occ_next();
        int n;
        n = q_addr.size();
        if (n > 0 && head_sent) begin
            n = n - 1;
        end
        if (store_mask != '0) begin
            n = n + 1;
        end
        return n;
    endfunction

    function automatic logic [XLEN-1:0] mask_bits(input logic [MASK_W-1:0] m);
        logic [XLEN-1:0] r;
        for (int b = 0; b < MASK_W; b++) begin
            r[8*b +: 8] = {8{m[b]}};
        end
        return r;
    endfunction

    // youngest exact match forwards, anything else sees the drained memory
    function automatic logic [XLEN-1:0] expected_load(input logic [XLEN-1:0] a,
                                                      input logic [MASK_W-1:0] m,
                                                      output bit hit);
        logic [XLEN-1:0] w;
        hit = 1'b0;
        w   = '0;
        for (int i = q_addr.size() - 1; i >= 0; i--) begin
            if (!hit && q_addr[i] == a && q_mask[i] == m) begin
                hit = 1'b1;
                w   = q_data[i];
            end
        end
        if (!hit) begin
            for (int b = 0; b < MASK_W; b++) begin
                w[8*b +: 8] = ref_bytes[int'(a[9:0]) + b];
            end
        end
        return w;
    endfunction

    function automatic logic [MASK_W-1:0] pick_mask();
        case ($urandom % 4)
            0: return 4'hF;
            1: return 4'h3;
            2: return 4'hC;
            default: return MASK_W'($urandom % 15 + 1);
        endcase
    endfunction

    task automatic idle_cycle();
        @(negedge clk);
        @(posedge clk);
        store_mask <= '0;
        load_mask  <= '0;
    endtask

    task automatic do_store(input logic [XLEN-1:0] a, input logic [XLEN-1:0] d,
                            input logic [MASK_W-1:0] m);
        int waited;
        waited = 0;
        @(negedge clk);
        while (occ_next() >= DEPTH) begin
            if (waited >= WAIT_MAX) begin
                timeout_abort("a free store buffer slot");
            end
            @(posedge clk);
            store_mask <= '0;
            load_mask  <= '0;
            @(negedge clk);
            waited++;
        end
        @(posedge clk);
        store_addr <= a;
        store_data <= d;
        store_mask <= m;
        load_mask  <= '0;
        for (int b = 0; b < MASK_W; b++) begin
            if (m[b]) begin
                ref_bytes[int'(a[9:0]) + b] = d[8*b +: 8];
            end
        end
    endtask

    task automatic do_load(input logic [XLEN-1:0] a, input logic [MASK_W-1:0] m);
        logic [XLEN-1:0] exp_w;
        logic [XLEN-1:0] sel;
        bit              hit;
        bit              was_empty;
        int              lat;
        @(negedge clk);
        @(posedge clk);
        load_addr  <= a;
        load_mask  <= m;
        store_mask <= '0;
        @(posedge clk);
        load_mask  <= '0;
        @(negedge clk);
        was_empty = (q_addr.size() == 0);
        exp_w     = expected_load(a, m, hit);
        lat       = 1;
        while (!load_resp) begin
            if (lat >= WAIT_MAX) begin
                timeout_abort("load_resp");
            end
            @(negedge clk);
            lat++;
        end
        sel = mask_bits(m);
        assert ((load_data & sel) == (exp_w & sel))
        else report_error($sformatf("load %h mask %h gave %h, expected %h",
                                    a, m, load_data & sel, exp_w & sel));
        if (hit) begin
            assert (lat == 1)
            else report_error($sformatf("forwarded load took %0d cycles", lat));
        end else if (was_empty) begin
            assert (lat == 2)
            else report_error($sformatf("load from empty buffer took %0d cycles", lat));
        end
    endtask

    initial begin
        int              waited;
        logic [XLEN-1:0] a;
        logic [MASK_W-1:0] m;
        clk        = 1'b0;
        rst        = 1'b1;
        store_addr = '0;
        store_data = '0;
        store_mask = '0;
        load_addr  = '0;
        load_mask  = '0;
        for (int i = 0; i < 1024; i++) begin
            ref_bytes[i] = 8'h00;
        end
        void'($urandom(32'h299d));
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        assert (!full && !store_resp && !load_resp)
        else report_error("outputs not idle after reset");
        do_load(32'h0, 4'hF);
        do_load(32'h14, 4'h6);
        do_load(32'h3fc, 4'hF);

        // two stores to one word, the younger one forwards
        do_store(32'h40, 32'h1111_1111, 4'hF);
        do_store(32'h20, 32'haaaa_5555, 4'hF);
        do_store(32'h20, 32'h1234_5678, 4'hF);
        do_load(32'h20, 4'hF);

        // partial overlap and no match both drain first
        do_store(32'h28, 32'hdead_beef, 4'hF);
        do_load(32'h28, 4'h3);
        do_load(32'h24, 4'hF);

        // one pop every two cycles, so 2*DEPTH-2 back-to-back stores fill it
        for (int i = 0; i < 2 * DEPTH - 2; i++) begin
            do_store(32'h80 + 4 * i, 32'hc0de_0000 + i, 4'hF);
        end
        idle_cycle();
        @(negedge clk);
        assert (full) else report_error("full low after the buffer filled");
        waited = 0;
        while (full) begin
            if (waited >= WAIT_MAX) begin
                timeout_abort("full to fall");
            end
            @(negedge clk);
            waited++;
        end
        for (int i = 0; i < 2 * DEPTH - 2; i++) begin
            do_load(32'h80 + 4 * i, 4'hF);
        end

        // random mix over eight words
        for (int n = 0; n < N_RANDOM; n++) begin
            a = ($urandom % 8) << 2;
            m = pick_mask();
            if ($urandom % 3 != 0) begin
                do_store(a, $urandom, m);
            end else begin
                do_load(a, m);
            end
        end

        idle_cycle();
        // the last store response still lands one cycle later
        repeat (2) @(negedge clk);
        $display("Done: no errors");
        $finish;
    end

endmodule : lsu_tb

`default_nettype wire

/* files.f */
+incdir+hw
hw/lsu_pkg.sv
hw/dcache_if.sv
hw/store_buffer.sv
hw/data_sram.sv
hw/lsu_top.sv
tests/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs lsu_tb with Verilator, exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module lsu_tb -o lsu_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/lsu_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished cleanly"
exit 0
